//--- files.f
verilog/kettle_pkg.sv
verilog/glyph_rom.sv
verilog/stage_sequencer.sv
verilog/temp_monitor.sv
verilog/matrix_scanner.sv
verilog/kettle_display_top.sv
test/tb_kettle_display.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the kettle display testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_kettle_display

rm -f "$LOG_FILE"

verilator --binary --timing -Wno-fatal \
    --top-module "$TOP" \
    --Mdir "$BUILD_DIR" \
    -o "$TOP" \
    -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "TEST RESULT: PASS" "$LOG_FILE"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG_FILE"
    exit 1
fi

//--- test/tb_kettle_display.sv
`timescale 1ns/1ps

module tb_kettle_display
    import kettle_pkg::*;
();

    typedef struct packed {
        logic [7:0] code;
        logic       hot;            // expected flag after the step
    } temp_step_t;

    localparam logic [31:0] SEED = 32'hfd53873d;

    // active-low row selects, row 0 first
    localparam logic [7:0] ROW_CODE [8] = '{
        8'hfe, 8'hfd, 8'hfb, 8'hf7, 8'hef, 8'hdf, 8'hbf, 8'h7f
    };

    // expected glyphs, row 0 first
    localparam logic [7:0] GLYPH [10][8] = '{
        '{8'h00, 8'h00, 8'h18, 8'h3c, 8'h3c, 8'h18, 8'h00, 8'h00},
        '{8'h00, 8'h00, 8'h3c, 8'h7e, 8'h7e, 8'h3c, 8'h00, 8'h00},
        '{8'h00, 8'h18, 8'h3c, 8'h7e, 8'h7e, 8'h3c, 8'h18, 8'h00},
        '{8'h00, 8'h3c, 8'h7e, 8'h7e, 8'h7e, 8'h7e, 8'h3c, 8'h00},
        '{8'h3c, 8'h7e, 8'hff, 8'hff, 8'hff, 8'hff, 8'h7e, 8'h3c},
        '{8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff},
        '{8'hc3, 8'he3, 8'hf1, 8'he3, 8'hc7, 8'he7, 8'hf7, 8'hfb},
        '{8'h00, 8'h01, 8'h81, 8'hc3, 8'h83, 8'hc7, 8'he7, 8'hf3},
        '{8'h00, 8'h38, 8'h44, 8'h5a, 8'h4a, 8'h32, 8'hc4, 8'h38},
        '{8'h00, 8'h00, 8'h60, 8'hfc, 8'h3f, 8'h3e, 8'h1c, 8'h00}
    };

    // walks below, through and above the band in both directions
    localparam temp_step_t TEMP_STEPS [11] = '{
        '{8'd100, 1'b0}, '{8'd170, 1'b0}, '{8'd179, 1'b0}, '{8'd180, 1'b1},
        '{8'd255, 1'b1}, '{8'd165, 1'b1}, '{8'd160, 1'b1}, '{8'd159, 1'b0},
        '{8'd175, 1'b0}, '{8'd200, 1'b1}, '{8'd0,   1'b0}
    };

    logic          clk;
    logic          rst;
    logic          st;
    logic [7:0]    temp_code;
    matrix_drive_t drive;
    panel_status_t status;

    int     errors = 0;
    int     failures = 0;
    int     checks = 0;
    int     cyc = 0;
    stage_t last_stage = '0;
    int     stable_cnt = 0;
    bit     seq_watch = 1'b0;
    int     last_change = 0;
    int     step_count = 0;
    logic   hot_model = 1'b0;
    stage_t shown_seen = '0;

    kettle_display_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .st        (st),
        .temp_code (temp_code),
        .drive     (drive),
        .status    (status)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    task automatic check_val(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
        checks++;
        if (actual !== expected)
        begin
            $display("[ERROR] %0t ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            errors++;
        end
    endtask

    // all sampling happens on the falling edge
    task automatic next_cycle();
        @(negedge clk);
        if (status.stage == last_stage)
            stable_cnt++;
        else
            stable_cnt = 0;
        if (seq_watch && status.stage != last_stage)
        begin
            check_val(cyc - last_change, TICKS_PER_STAGE, "cycles between stage steps");
            check_val(status.stage, stage_t'(last_stage + 1), "stage step value");
            step_count++;
            last_change = cyc;
        end
        check_val(status.done, status.stage == STAGE_LAST, "done flag");
        last_stage = status.stage;
    endtask

    task automatic check_reset_values();
        check_val(drive.row, 8'hff, "row in reset");
        check_val(drive.colg, 8'h00, "colg in reset");
        check_val(drive.colr, 8'h00, "colr in reset");
        check_val(status.stage, 4'd0, "stage in reset");
        check_val(status.done, 1'b0, "done in reset");
        check_val(status.hot, 1'b0, "hot in reset");
    endtask

    task automatic wait_frame_start();
        int n;
        bit found;
        found = 1'b0;
        for (n = 0; n < 2 * ROWS && !found; n++)
        begin
            next_cycle();
            if (drive.row == 8'hfe)
                found = 1'b1;
        end
        if (!found)
        begin
            $display("timeout: row 0 was not driven within %0d cycles", 2 * ROWS);
            failures++;
        end
    endtask

    task automatic wait_stage_steady(input stage_t target, input int max_cycles);
        int n;
        bit found;
        found = 1'b0;
        for (n = 0; n < max_cycles && !found; n++)
        begin
            next_cycle();
            if (status.stage == target && stable_cnt >= 4)
                found = 1'b1;
        end
        if (!found)
        begin
            $display("timeout: stage did not settle at %0d within %0d cycles",
                     target, max_cycles);
            failures++;
        end
    endtask

    task automatic capture_frame(input logic hot_exp, input logic blank_exp);
        logic [7:0] row_q [ROWS];
        logic [7:0] colg_q [ROWS];
        logic [7:0] colr_q [ROWS];
        logic [7:0] row_exp;
        logic [7:0] colg_exp;
        stage_t     s_start;
        int         attempt;
        int         k;
        bit         accepted;
        accepted = 1'b0;
        s_start = '0;
        for (attempt = 0; attempt < 4 && !accepted; attempt++)
        begin
            wait_frame_start();
            s_start = status.stage;
            accepted = blank_exp || stable_cnt >= 3;  // glyph latched two edges back
            for (k = 0; k < ROWS; k++)
            begin
                if (k > 0)
                    next_cycle();
                row_q[k]  = drive.row;
                colg_q[k] = drive.colg;
                colr_q[k] = drive.colr;
            end
            if (!blank_exp && status.stage != s_start)
                accepted = 1'b0;
        end
        if (!accepted)
        begin
            $display("no frame with one steady stage was found in 4 attempts");
            failures++;
        end
        else
        begin
            for (k = 0; k < ROWS; k++)
            begin
                row_exp = ROW_CODE[k];
                colg_exp = (blank_exp || s_start > STAGE_LAST) ? 8'h00 : GLYPH[s_start][k];
                check_val(row_q[k], row_exp, "row within frame");
                check_val(colg_q[k], colg_exp, "green column pattern");
                check_val(colr_q[k], hot_exp ? colg_exp : 8'h00, "red column pattern");
            end
        end
        shown_seen = s_start;
    endtask

    function automatic logic [7:0] band_code();
        return TEMP_HOT_OFF + 8'($urandom % (TEMP_HOT_ON - TEMP_HOT_OFF));
    endfunction

    // hot must move exactly one edge after the code
    task automatic apply_temp(input logic [7:0] code, input logic hot_exp);
        @(posedge clk);
        temp_code <= code;
        next_cycle();
        check_val(status.hot, hot_model, "hot before the sampling edge");
        next_cycle();
        check_val(status.hot, hot_exp, "hot after a code step");
        hot_model = hot_exp;
        @(posedge clk);
        temp_code <= band_code();
        next_cycle();
        next_cycle();
        check_val(status.hot, hot_model, "hot holds inside the band");
    endtask

    initial
    begin
        int i;
        int k;
        int s;
        logic [7:0] row_exp;
        rst = 1'b1;
        st = 1'b0;
        temp_code = 8'd0;
        void'($urandom(SEED));

        for (i = 0; i < 2; i++)
        begin
            next_cycle();
            check_reset_values();
        end
        @(posedge clk);
        rst <= 1'b0;
        next_cycle();
        check_reset_values();

        wait_frame_start();
        for (k = 0; k < 3 * ROWS; k++)
        begin
            if (k > 0)
                next_cycle();
            row_exp = ROW_CODE[k % ROWS];
            check_val(drive.row, row_exp, "row scan order");
        end
        capture_frame(1'b0, 1'b1);      // st low, blank

        @(posedge clk);
        st <= 1'b1;
        next_cycle();
        last_change = cyc;
        step_count = 0;
        seq_watch = 1'b1;
        for (s = 0; s <= int'(STAGE_LAST); s++)
        begin
            @(posedge clk);
            temp_code <= band_code();
            wait_stage_steady(stage_t'(s), 2 * TICKS_PER_STAGE);
            capture_frame(1'b0, 1'b0);
            check_val(shown_seen, s, "displayed stage");
        end
        repeat (TICKS_PER_STAGE + 8) next_cycle();
        check_val(status.stage, STAGE_LAST, "stage held at the last stage");
        check_val(step_count, 9, "number of stage steps");
        seq_watch = 1'b0;

        @(posedge clk);
        st <= 1'b0;
        next_cycle();
        check_val(status.stage, STAGE_LAST, "stage on the edge that drops st");
        next_cycle();
        check_val(status.stage, 4'd0, "stage after st dropped");
        capture_frame(1'b0, 1'b1);

        for (i = 0; i < 11; i++)
            apply_temp(TEMP_STEPS[i].code, TEMP_STEPS[i].hot);

        // red overlay over a full square
        @(posedge clk);
        st <= 1'b1;
        wait_stage_steady(4'd5, 6 * TICKS_PER_STAGE + 16);
        apply_temp(8'd200, 1'b1);
        capture_frame(1'b1, 1'b0);
        check_val(shown_seen, 5, "stage of the hot frame");
        apply_temp(8'd100, 1'b0);
        capture_frame(1'b0, 1'b0);
        check_val(shown_seen, 5, "stage of the cool frame");

        $display("checks run: %0d, value errors: %0d, other failures: %0d",
                 checks, errors, failures);
        if (errors == 0 && failures == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- verilog/glyph_rom.sv
`timescale 1ns/1ps

module glyph_rom
    import kettle_pkg::*;
(
    input  stage_t     stage,
    input  row_idx_t   row_idx,
    output logic [7:0] pattern
);

    always_comb
    begin
        pattern = 8'b0000_0000;
        case (stage)
            4'd0:                       // small blob
            begin
                case (row_idx)
                    3'd2, 3'd5: pattern = 8'b0001_1000;
                    3'd3, 3'd4: pattern = 8'b0011_1100;
                    default:    pattern = 8'b0000_0000;
                endcase
            end
            4'd1:
            begin
                case (row_idx)
                    3'd2, 3'd5: pattern = 8'b0011_1100;
                    3'd3, 3'd4: pattern = 8'b0111_1110;
                    default:    pattern = 8'b0000_0000;
                endcase
            end
            4'd2:
            begin
                case (row_idx)
                    3'd1, 3'd6: pattern = 8'b0001_1000;
                    3'd2, 3'd5: pattern = 8'b0011_1100;
                    3'd3, 3'd4: pattern = 8'b0111_1110;
                    default:    pattern = 8'b0000_0000;
                endcase
            end
            4'd3:
            begin
                case (row_idx)
                    3'd1, 3'd6: pattern = 8'b0011_1100;
                    3'd2, 3'd5: pattern = 8'b0111_1110;
                    3'd3, 3'd4: pattern = 8'b0111_1110;
                    default:    pattern = 8'b0000_0000;
                endcase
            end
            4'd4:                       // blob almost fills the matrix
            begin
                case (row_idx)
                    3'd0, 3'd7: pattern = 8'b0011_1100;
                    3'd1, 3'd6: pattern = 8'b0111_1110;
                    default:    pattern = 8'b1111_1111;
                endcase
            end
            4'd5:
            begin
                pattern = 8'b1111_1111;
            end
            4'd6:                       // first bubbles rising
            begin
                case (row_idx)
                    3'd0: pattern = 8'b1100_0011;
                    3'd1: pattern = 8'b1110_0011;
                    3'd2: pattern = 8'b1111_0001;
                    3'd3: pattern = 8'b1110_0011;
                    3'd4: pattern = 8'b1100_0111;
                    3'd5: pattern = 8'b1110_0111;
                    3'd6: pattern = 8'b1111_0111;
                    3'd7: pattern = 8'b1111_1011;
                    default: pattern = 8'b0000_0000;
                endcase
            end
            4'd7:
            begin
                case (row_idx)
                    3'd1: pattern = 8'b0000_0001;
                    3'd2: pattern = 8'b1000_0001;
                    3'd3: pattern = 8'b1100_0011;
                    3'd4: pattern = 8'b1000_0011;
                    3'd5: pattern = 8'b1100_0111;
                    3'd6: pattern = 8'b1110_0111;
                    3'd7: pattern = 8'b1111_0011;
                    default: pattern = 8'b0000_0000;
                endcase
            end
            4'd8:                       // single large bubble
            begin
                case (row_idx)
                    3'd1: pattern = 8'b0011_1000;
                    3'd2: pattern = 8'b0100_0100;
                    3'd3: pattern = 8'b0101_1010;
                    3'd4: pattern = 8'b0100_1010;
                    3'd5: pattern = 8'b0011_0010;
                    3'd6: pattern = 8'b1100_0100;
                    3'd7: pattern = 8'b0011_1000;
                    default: pattern = 8'b0000_0000;
                endcase
            end
            4'd9:                       // steam plume, boiled
            begin
                case (row_idx)
                    3'd2: pattern = 8'b0110_0000;
                    3'd3: pattern = 8'b1111_1100;
                    3'd4: pattern = 8'b0011_1111;
                    3'd5: pattern = 8'b0011_1110;
                    3'd6: pattern = 8'b0001_1100;
                    default: pattern = 8'b0000_0000;
                endcase
            end
            default:
            begin
                pattern = 8'b0000_0000;
            end
        endcase
    end

endmodule

//--- verilog/kettle_display_top.sv
`timescale 1ns/1ps

module kettle_display_top
    import kettle_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          st,
    input  logic [7:0]    temp_code,
    output matrix_drive_t drive,
    output panel_status_t status
);

    stage_t     stage;
    logic       done;
    logic       hot;
    row_idx_t   row_idx;
    stage_t     shown_stage;
    logic [7:0] pattern;

    stage_sequencer i_seq (
        .clk   (clk),
        .rst   (rst),
        .st    (st),
        .stage (stage),
        .done  (done)
    );

    temp_monitor i_temp (
        .clk       (clk),
        .rst       (rst),
        .temp_code (temp_code),
        .hot       (hot)
    );

    matrix_scanner i_scan (
        .clk         (clk),
        .rst         (rst),
        .st          (st),
        .hot         (hot),
        .stage       (stage),
        .pattern     (pattern),
        .row_idx     (row_idx),
        .shown_stage (shown_stage),
        .drive       (drive)
    );

    // rom is looked up with the frame-latched stage
    glyph_rom i_rom (
        .stage   (shown_stage),
        .row_idx (row_idx),
        .pattern (pattern)
    );

    assign status = '{stage: stage, done: done, hot: hot};

endmodule

//--- verilog/kettle_pkg.sv
package kettle_pkg;

    typedef logic [3:0] stage_t;      // heating stage 0..9
    typedef logic [2:0] row_idx_t;

    // display pins, one row lit at a time
    typedef struct packed {
        logic [7:0] row;              // active low, one-hot
        logic [7:0] colg;
        logic [7:0] colr;
    } matrix_drive_t;

    typedef struct packed {
        stage_t stage;
        logic   done;                 // stage at STAGE_LAST
        logic   hot;
    } panel_status_t;

    localparam stage_t STAGE_LAST = 4'd9;

    // short stage time for simulation
    localparam int TICKS_PER_STAGE = 64;
    localparam int TICK_W = $clog2(TICKS_PER_STAGE);

    // hysteresis band of the sensor code
    localparam logic [7:0] TEMP_HOT_ON  = 8'd180;
    localparam logic [7:0] TEMP_HOT_OFF = 8'd160;

    localparam int ROWS = 8;

endpackage

//--- verilog/matrix_scanner.sv
`timescale 1ns/1ps

module matrix_scanner
    import kettle_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          st,
    input  logic          hot,
    input  stage_t        stage,
    input  logic [7:0]    pattern,
    output row_idx_t      row_idx,
    output stage_t        shown_stage,
    output matrix_drive_t drive
);

    row_idx_t   row_cnt;
    logic       shown_st;
    logic       frame_end;
    logic [7:0] colg_next;

    assign frame_end = (row_cnt == row_idx_t'(ROWS - 1));
    assign row_idx   = row_cnt;
    assign colg_next = shown_st ? pattern : 8'b0000_0000;

    // free running row counter, stage and st latched once per frame
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_cnt     <= '0;
            shown_stage <= '0;
            shown_st    <= 1'b0;
        end
        else
        begin
            row_cnt <= frame_end ? '0 : row_cnt + row_idx_t'(1);
            if (frame_end)
            begin
                shown_stage <= stage;
                shown_st    <= st;
            end
        end
    end

    // row and columns leave together from the same index
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            drive.row  <= 8'b1111_1111;   // all rows off
            drive.colg <= 8'b0000_0000;
            drive.colr <= 8'b0000_0000;
        end
        else
        begin
            drive.row  <= ~(8'b0000_0001 << row_cnt);
            drive.colg <= colg_next;
            drive.colr <= hot ? colg_next : 8'b0000_0000;  // red overlay when hot
        end
    end

endmodule

//--- verilog/stage_sequencer.sv
`timescale 1ns/1ps

module stage_sequencer
    import kettle_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   st,
    output stage_t stage,
    output logic   done
);

    logic [TICK_W-1:0] tick;
    logic              tick_wrap;
    stage_t            stage_next;

    assign tick_wrap = (tick == TICK_W'(TICKS_PER_STAGE - 1));

    always_comb
    begin
        stage_next = stage;
        if (!st)
            stage_next = '0;            // st low restarts the sequence
        else if (stage != STAGE_LAST && tick_wrap)
            stage_next = stage + stage_t'(1);
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tick  <= '0;
            stage <= '0;
            done  <= 1'b0;
        end
        else
        begin
            if (!st || stage == STAGE_LAST || tick_wrap)
                tick <= '0;
            else
                tick <= tick + 1'b1;
            stage <= stage_next;
            done  <= (stage_next == STAGE_LAST);  // follows stage exactly
        end
    end

endmodule

//--- verilog/temp_monitor.sv
`timescale 1ns/1ps

module temp_monitor
    import kettle_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] temp_code,
    output logic       hot
);

    logic set_hot;
    logic clr_hot;

    assign set_hot = (temp_code >= TEMP_HOT_ON);
    assign clr_hot = (temp_code < TEMP_HOT_OFF);

    // between the two thresholds the flag holds
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            hot <= 1'b0;
        else if (set_hot)
            hot <= 1'b1;
        else if (clr_hot)
            hot <= 1'b0;
    end

endmodule
